//--- bench/dbgTb.sv
/*
  Debug control testbench
  Directed tests of SPR access, IAC and DAC matching, flush and debug modes.
*/
`timescale 1ns/1ps

module dbgTb;

  localparam int WaitLimit = 40;

  logic            CB;
  logic            reset;
  logic            sprReqValid;
  dbgPkg::sprReq_t sprReq;
  logic            sprReqReady;
  logic            sprRspValid;
  logic [31:0]     sprRspData;
  logic            sprRspReady;
  dbgPkg::iacCmp_t instCmp;
  dbgPkg::dacCmp_t dataCmp;
  logic            wbFlush;
  logic            msrDE;
  logic            debugIntrp;
  logic            stopReq;

  int errCount;
  int passCount;
  int failCount;

  dbgTop UUT
  (
    .CB          (CB),
    .reset       (reset),
    .sprReqValid (sprReqValid),
    .sprReq      (sprReq),
    .sprReqReady (sprReqReady),
    .sprRspValid (sprRspValid),
    .sprRspData  (sprRspData),
    .sprRspReady (sprRspReady),
    .instCmp     (instCmp),
    .dataCmp     (dataCmp),
    .wbFlush     (wbFlush),
    .msrDE       (msrDE),
    .debugIntrp  (debugIntrp),
    .stopReq     (stopReq)
  );

  always #50 CB = ~CB;

  // **************************************************************************
  // Helpers
  // **************************************************************************

  // Big-endian SPR bit n where bit 0 is the MSB
  function automatic logic [31:0] bitWord(input int n);
    return 32'h8000_0000 >> n;
  endfunction

  function automatic logic [31:0] fieldWord(input int first, input int width);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < width; i++)
      w = w | bitWord(first + i);
    return w;
  endfunction

  function automatic dbgPkg::iacCmp_t instAt(input logic [3:0] eq, input logic [3:0] gt);
    return '{valid: 1'b1, eq: eq, gt: gt};
  endfunction

  function automatic dbgPkg::dacCmp_t dataAt(input logic store, input logic [1:0] eq,
                                             input logic [1:0] gt);
    return '{valid: 1'b1, isStore: store, eq: eq, gt: gt};
  endfunction

  task automatic checkVal(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      errCount++;
    end
  endtask

  task automatic abortRun(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic waitReady();
    int waitCnt;
    waitCnt = 0;
    @(negedge CB);
    while (!sprReqReady)
    begin
      waitCnt++;
      if (waitCnt > WaitLimit)
        abortRun("sprReqReady");
      @(negedge CB);
    end
  endtask

  task automatic issueReq(input logic write, input dbgPkg::sprSel_e sel,
                          input logic [31:0] data);
    @(posedge CB);
    sprReqValid <= 1'b1;
    sprReq      <= '{write: write, sel: sel, data: data};
    waitReady();
    // Accepted at this edge
    @(posedge CB);
    sprReqValid <= 1'b0;
  endtask

  task automatic waitRsp(output logic [31:0] data);
    int waitCnt;
    waitCnt = 0;
    @(negedge CB);
    while (!sprRspValid)
    begin
      waitCnt++;
      if (waitCnt > WaitLimit)
        abortRun("sprRspValid");
      @(negedge CB);
    end
    data = sprRspData;
  endtask

  task automatic sprWrite(input dbgPkg::sprSel_e sel, input logic [31:0] data);
    issueReq(1'b1, sel, data);
  endtask

  task automatic sprRead(input dbgPkg::sprSel_e sel, output logic [31:0] data);
    issueReq(1'b0, sel, '0);
    waitRsp(data);
  endtask

  task automatic readCheck(input string name, input dbgPkg::sprSel_e sel,
                           input logic [31:0] expected);
    logic [31:0] data;
    sprRead(sel, data);
    checkVal(name, expected, data);
  endtask

  // One compare cycle that may be flushed in writeback
  task automatic pulseCmp(input dbgPkg::iacCmp_t ic, input dbgPkg::dacCmp_t dc,
                          input logic flush);
    @(posedge CB);
    instCmp <= ic;
    dataCmp <= dc;
    @(posedge CB);
    instCmp <= '0;
    dataCmp <= '0;
    wbFlush <= flush;
    @(posedge CB);
    wbFlush <= 1'b0;
  endtask

  task automatic eventCase(input string name, input dbgPkg::iacCmp_t ic,
                           input dbgPkg::dacCmp_t dc, input logic [31:0] expected);
    pulseCmp(ic, dc, 1'b0);
    readCheck(name, dbgPkg::SelDbsr, expected);
    sprWrite(dbgPkg::SelDbsr, 32'hFFFF_FFFF);
  endtask

  task automatic clearRegs();
    sprWrite(dbgPkg::SelDbcr0, 32'h0);
    sprWrite(dbgPkg::SelDbcr1, 32'h0);
    sprWrite(dbgPkg::SelDbsr, 32'hFFFF_FFFF);
  endtask

  task automatic reportTest(input string name, input int startErr);
    if (errCount == startErr)
    begin
      $display("test %s: ok", name);
      passCount++;
    end
    else
    begin
      $display("test %s: FAIL with %0d errors", name, errCount - startErr);
      failCount++;
    end
  endtask

  // **************************************************************************
  // Tests
  // **************************************************************************

  task automatic testSprAccess();
    int          startErr;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] held;
    logic [31:0] dbcr0Mask;
    logic [31:0] dbcr1Mask;
    startErr  = errCount;
    dbcr0Mask = bitWord(0) | bitWord(1) | fieldWord(8, 6);
    dbcr1Mask = fieldWord(0, 4) | bitWord(8);
    d0 = '0;
    d1 = '0;
    // State right after reset
    @(negedge CB);
    checkVal("sprReqReady", 32'd1, 32'(sprReqReady));
    checkVal("sprRspValid", 32'd0, 32'(sprRspValid));
    checkVal("debugIntrp", 32'd0, 32'(debugIntrp));
    checkVal("stopReq", 32'd0, 32'(stopReq));
    for (int i = 0; i < 4; i++)
    begin
      d0 = $urandom;
      sprWrite(dbgPkg::SelDbcr0, d0);
      readCheck("DBCR0", dbgPkg::SelDbcr0, d0 & dbcr0Mask);
      d1 = $urandom;
      sprWrite(dbgPkg::SelDbcr1, d1);
      readCheck("DBCR1", dbgPkg::SelDbcr1, d1 & dbcr1Mask);
    end
    readCheck("SelNone", dbgPkg::SelNone, 32'h0);
    // Hold a response and queue a second read behind it
    @(posedge CB);
    sprRspReady <= 1'b0;
    sprRead(dbgPkg::SelDbcr1, held);
    checkVal("sprRspData", d1 & dbcr1Mask, held);
    @(posedge CB);
    sprReqValid <= 1'b1;
    sprReq      <= '{write: 1'b0, sel: dbgPkg::SelDbcr0, data: '0};
    repeat (3)
    begin
      @(negedge CB);
      checkVal("sprReqReady", 32'd0, 32'(sprReqReady));
      checkVal("sprRspValid", 32'd1, 32'(sprRspValid));
      checkVal("sprRspData", held, sprRspData);
    end
    @(posedge CB);
    sprRspReady <= 1'b1;
    waitReady();
    @(posedge CB);
    sprReqValid <= 1'b0;
    waitRsp(held);
    checkVal("DBCR0", d0 & dbcr0Mask, held);
    clearRegs();
    reportTest("spr access", startErr);
  endtask

  task automatic testIacExact();
    int startErr;
    startErr = errCount;
    // IDM with IAC2 enabled
    sprWrite(dbgPkg::SelDbcr0, bitWord(1) | bitWord(9));
    @(posedge CB);
    msrDE <= 1'b1;
    pulseCmp(instAt(4'b0100, 4'b0000), '0, 1'b0);
    readCheck("DBSR", dbgPkg::SelDbsr, bitWord(9));
    @(negedge CB);
    checkVal("debugIntrp", 32'd1, 32'(debugIntrp));
    sprWrite(dbgPkg::SelDbsr, bitWord(9));
    readCheck("DBSR", dbgPkg::SelDbsr, 32'h0);
    @(negedge CB);
    checkVal("debugIntrp", 32'd0, 32'(debugIntrp));
    clearRegs();
    reportTest("iac exact", startErr);
  endtask

  task automatic testIacRange();
    int startErr;
    startErr = errCount;
    // IDM with IAC1 and IAC2 enabled as a range
    sprWrite(dbgPkg::SelDbcr0, bitWord(1) | fieldWord(8, 2) | bitWord(12));
    eventCase("DBSR inside", instAt(4'b0000, 4'b0100), '0, bitWord(8));
    eventCase("DBSR below", instAt(4'b0000, 4'b1100), '0, 32'h0);
    eventCase("DBSR above", instAt(4'b0000, 4'b0000), '0, 32'h0);
    eventCase("DBSR eq2 only", instAt(4'b0100, 4'b0000), '0, 32'h0);
    clearRegs();
    reportTest("iac range", startErr);
  endtask

  task automatic testDac();
    int startErr;
    startErr = errCount;
    sprWrite(dbgPkg::SelDbcr0, bitWord(1));
    sprWrite(dbgPkg::SelDbcr1, bitWord(0));
    eventCase("DBSR load", '0, dataAt(1'b0, 2'b10, 2'b00), bitWord(12));
    eventCase("DBSR store", '0, dataAt(1'b1, 2'b10, 2'b00), 32'h0);
    // DAC1 write enable in range mode
    sprWrite(dbgPkg::SelDbcr1, bitWord(2) | bitWord(8));
    eventCase("DBSR store range", '0, dataAt(1'b1, 2'b00, 2'b01), bitWord(14));
    clearRegs();
    reportTest("dac", startErr);
  endtask

  task automatic testFlushModes();
    int startErr;
    startErr = errCount;
    sprWrite(dbgPkg::SelDbcr0, bitWord(1) | bitWord(8));
    pulseCmp(instAt(4'b1000, 4'b0000), '0, 1'b1);
    readCheck("DBSR flushed", dbgPkg::SelDbsr, 32'h0);
    // Neither debug mode
    sprWrite(dbgPkg::SelDbcr0, bitWord(8));
    eventCase("DBSR no mode", instAt(4'b1000, 4'b0000), '0, 32'h0);
    // External mode wins over internal
    sprWrite(dbgPkg::SelDbcr0, bitWord(0) | bitWord(1) | bitWord(8));
    pulseCmp(instAt(4'b1000, 4'b0000), '0, 1'b0);
    readCheck("DBSR edm", dbgPkg::SelDbsr, bitWord(8));
    @(negedge CB);
    checkVal("stopReq", 32'd1, 32'(stopReq));
    checkVal("debugIntrp", 32'd0, 32'(debugIntrp));
    clearRegs();
    @(negedge CB);
    checkVal("stopReq", 32'd0, 32'(stopReq));
    reportTest("flush and modes", startErr);
  endtask

  initial
  begin
    void'($urandom(32'h516ca147));
    CB          = 1'b0;
    reset       = 1'b1;
    sprReqValid = 1'b0;
    sprReq      = '0;
    sprRspReady = 1'b1;
    instCmp     = '0;
    dataCmp     = '0;
    wbFlush     = 1'b0;
    msrDE       = 1'b0;
    errCount    = 0;
    passCount   = 0;
    failCount   = 0;
    repeat (8) @(posedge CB);
    reset <= 1'b0;

    testSprAccess();
    testIacExact();
    testIacRange();
    testDac();
    testFlushModes();

    $display("summary: %0d passed, %0d failed, %0d check errors",
             passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- filelist.f
rtl/dbgPkg.sv
rtl/dbgSprRegs.sv
rtl/dbgIacMatch.sv
rtl/dbgDacMatch.sv
rtl/dbgEventCtl.sv
rtl/dbgTop.sv
bench/dbgTb.sv

//--- rtl/dbgDacMatch.sv
/*
  Data address compare
  Exact or range matching of loads and stores against the two DAC
  channels, registered into the writeback stage.
*/
`timescale 1ns/1ps

module dbgDacMatch
(
  input  logic                    CB,
  input  logic                    reset,
  input  dbgPkg::dbgCtl_t         ctl,
  input  dbgPkg::dacCmp_t         dataCmp,
  output logic [1:dbgPkg::NumDac] wbDacRdHit,
  output logic [1:dbgPkg::NumDac] wbDacWrHit
);

  logic [1:dbgPkg::NumDac] nxtRdHit;
  logic [1:dbgPkg::NumDac] nxtWrHit;
  logic                    inRange;

  // DAC1 is the inclusive lower bound, DAC2 the exclusive upper one
  assign inRange = ~dataCmp.gt[1] & dataCmp.gt[dbgPkg::NumDac];

  always_comb
  begin
    logic chHit;

    nxtRdHit = '0;
    nxtWrHit = '0;
    for (int n = 1; n <= dbgPkg::NumDac; n++)
    begin
      // Only DAC1 reports a range hit
      if (ctl.dacRng)
        chHit = (n == 1) & inRange;
      else
        chHit = dataCmp.eq[n];
      nxtRdHit[n] = chHit & ctl.dacRdEn[n] & ~dataCmp.isStore;
      nxtWrHit[n] = chHit & ctl.dacWrEn[n] & dataCmp.isStore;
    end
  end

  // Writeback-stage event register
  always_ff @(posedge CB)
  begin
    if (reset)
    begin
      wbDacRdHit <= '0;
      wbDacWrHit <= '0;
    end
    else if (dataCmp.valid)
    begin
      wbDacRdHit <= nxtRdHit;
      wbDacWrHit <= nxtWrHit;
    end
    else
    begin
      wbDacRdHit <= '0;
      wbDacWrHit <= '0;
    end
  end

endmodule

//--- rtl/dbgEventCtl.sv
/*
  Debug event control
  Qualifies writeback events by flush and debug mode into the DBSR set
  vector, and raises the debug interrupt or stop request.
*/
`timescale 1ns/1ps

module dbgEventCtl
(
  input  dbgPkg::dbgCtl_t         ctl,
  input  logic [1:dbgPkg::NumIac] wbIacHit,
  input  logic [1:dbgPkg::NumDac] wbDacRdHit,
  input  logic [1:dbgPkg::NumDac] wbDacWrHit,
  input  logic                    wbFlush,
  input  logic                    msrDE,
  input  dbgPkg::dbgEvents_t      dbsrEvents,
  output dbgPkg::dbgEvents_t      eventSet,
  output logic                    debugIntrp,
  output logic                    stopReq
);

  dbgPkg::dbgEvents_t wbEvents;
  logic               recordEn;
  logic               anyHit;

  // **************************************************************************
  // Event recording
  // **************************************************************************

  always_comb
  begin
    wbEvents.iacHit   = wbIacHit;
    wbEvents.dacRdHit = wbDacRdHit;
    wbEvents.dacWrHit = wbDacWrHit;
  end

  // Flushed instructions and disabled debug record nothing
  assign recordEn = ~wbFlush & (ctl.edm | ctl.idm);

  always_comb
  begin
    if (recordEn)
      eventSet = wbEvents;
    else
      eventSet = '0;
  end

  // **************************************************************************
  // Debug requests
  // **************************************************************************

  assign anyHit = |dbsrEvents;

  // External mode stops the core
  assign stopReq = ctl.edm & anyHit;

  // Internal mode takes an interrupt, external mode has priority
  assign debugIntrp = ctl.idm & ~ctl.edm & msrDE & anyHit;

endmodule

//--- rtl/dbgIacMatch.sv
/*
  Instruction address compare
  Exact or paired range matching of the four IAC channels, registered
  into the writeback stage.
*/
`timescale 1ns/1ps

module dbgIacMatch
(
  input  logic                    CB,
  input  logic                    reset,
  input  dbgPkg::dbgCtl_t         ctl,
  input  dbgPkg::iacCmp_t         instCmp,
  output logic [1:dbgPkg::NumIac] wbIacHit
);

  logic [1:dbgPkg::NumIac] nxtHit;

  // Channels work in pairs, IAC1/IAC2 and IAC3/IAC4
  always_comb
  begin
    int   lo;
    int   hi;
    logic rng;

    nxtHit = '0;
    for (int p = 0; p < dbgPkg::NumIac / 2; p++)
    begin
      lo  = 2 * p + 1;
      hi  = 2 * p + 2;
      rng = (p == 0) ? ctl.iac12Rng : ctl.iac34Rng;
      if (rng)
      begin
        // Lower bound inclusive, upper bound exclusive
        nxtHit[lo] = ctl.iacEn[lo] & ~instCmp.gt[lo] & instCmp.gt[hi];
      end
      else
      begin
        nxtHit[lo] = ctl.iacEn[lo] & instCmp.eq[lo];
        nxtHit[hi] = ctl.iacEn[hi] & instCmp.eq[hi];
      end
    end
  end

  // Writeback-stage event register, empty when no instruction moves
  always_ff @(posedge CB)
  begin
    if (reset)
      wbIacHit <= '0;
    else if (instCmp.valid)
      wbIacHit <= nxtHit;
    else
      wbIacHit <= '0;
  end

endmodule

//--- rtl/dbgPkg.sv
/*
  Debug control definitions
  Register field positions, write masks, SPR selector and the structs
  shared by the debug blocks. Bit 0 is the MSB of an SPR word.
*/
package dbgPkg;

  localparam int SprWidth  = 32;
  localparam int NumIac    = 4;
  localparam int NumDac    = 2;
  localparam int NumEvents = NumIac + 2 * NumDac;

  typedef logic [0:SprWidth-1] sprWord_t;

  // **************************************************************************
  // Register field positions, big-endian numbering
  // **************************************************************************

  // DBCR0
  localparam int Dbcr0Edm      = 0;
  localparam int Dbcr0Idm      = 1;
  localparam int Dbcr0IacEn    = 8;
  localparam int Dbcr0Iac12Rng = 12;
  localparam int Dbcr0Iac34Rng = 13;

  // DBCR1
  localparam int Dbcr1DacRdEn = 0;
  localparam int Dbcr1DacWrEn = 2;
  localparam int Dbcr1DacRng  = 8;

  // DBSR hit fields, bits 8 to 15
  localparam int DbsrIacHit   = 8;
  localparam int DbsrDacRdHit = 12;
  localparam int DbsrDacWrHit = 14;

  // Implemented bits of each register
  localparam sprWord_t Dbcr0WrMask = 32'hC0FC_0000;
  localparam sprWord_t Dbcr1WrMask = 32'hF080_0000;
  localparam sprWord_t DbsrMask    = 32'h00FF_0000;

  // **************************************************************************
  // SPR access and block interface types
  // **************************************************************************

  typedef enum logic [1:0]
  {
    SelDbcr0,
    SelDbcr1,
    SelDbsr,
    SelNone
  } sprSel_e;

  typedef struct packed
  {
    logic     write;
    sprSel_e  sel;
    sprWord_t data;
  } sprReq_t;

  // Instruction address compare results from the fetch side
  typedef struct packed
  {
    logic              valid;
    logic [1:NumIac]   eq;
    logic [1:NumIac]   gt;
  } iacCmp_t;

  // Effective address compare results for a load or store
  typedef struct packed
  {
    logic              valid;
    logic              isStore;
    logic [1:NumDac]   eq;
    logic [1:NumDac]   gt;
  } dacCmp_t;

  // Same order as DBSR bits 8 to 15
  typedef struct packed
  {
    logic [1:NumIac] iacHit;
    logic [1:NumDac] dacRdHit;
    logic [1:NumDac] dacWrHit;
  } dbgEvents_t;

  typedef struct packed
  {
    logic            edm;
    logic            idm;
    logic [1:NumIac] iacEn;
    logic            iac12Rng;
    logic            iac34Rng;
    logic [1:NumDac] dacRdEn;
    logic [1:NumDac] dacWrEn;
    logic            dacRng;
  } dbgCtl_t;

endpackage

//--- rtl/dbgSprRegs.sv
/*
  Debug SPR register block
  Holds DBCR0, DBCR1 and DBSR behind a valid/ready access port with a
  held read response, and decodes the control fields.
*/
`timescale 1ns/1ps

module dbgSprRegs
(
  input  logic                        CB,
  input  logic                        reset,
  input  logic                        sprReqValid,
  input  dbgPkg::sprReq_t             sprReq,
  output logic                        sprReqReady,
  output logic                        sprRspValid,
  output logic [0:dbgPkg::SprWidth-1] sprRspData,
  input  logic                        sprRspReady,
  input  dbgPkg::dbgEvents_t          eventSet,
  output dbgPkg::dbgCtl_t             ctl,
  output dbgPkg::dbgEvents_t          dbsrEvents
);

  dbgPkg::sprWord_t   dbcr0;
  dbgPkg::sprWord_t   dbcr1;
  dbgPkg::dbgEvents_t dbsr;
  dbgPkg::sprWord_t   dbsrWord;
  dbgPkg::sprWord_t   clrWord;
  dbgPkg::dbgEvents_t dbsrClr;
  dbgPkg::sprWord_t   rdWord;
  logic               reqFire;
  logic               wrFire;
  logic               rdFire;

  // **************************************************************************
  // Request handshake
  // **************************************************************************

  // Stall only while a read response is waiting
  assign sprReqReady = ~(sprRspValid & ~sprRspReady);
  assign reqFire     = sprReqValid & sprReqReady;
  assign wrFire      = reqFire & sprReq.write;
  assign rdFire      = reqFire & ~sprReq.write;

  // DBSR hit bits placed in SPR word form
  always_comb
  begin
    dbsrWord = '0;
    dbsrWord[dbgPkg::DbsrIacHit +: dbgPkg::NumIac]   = dbsr.iacHit;
    dbsrWord[dbgPkg::DbsrDacRdHit +: dbgPkg::NumDac] = dbsr.dacRdHit;
    dbsrWord[dbgPkg::DbsrDacWrHit +: dbgPkg::NumDac] = dbsr.dacWrHit;
  end

  // Write-one-to-clear vector for DBSR
  always_comb
  begin
    clrWord = '0;
    if (wrFire && sprReq.sel == dbgPkg::SelDbsr)
      clrWord = sprReq.data & dbgPkg::DbsrMask;
    dbsrClr.iacHit   = clrWord[dbgPkg::DbsrIacHit +: dbgPkg::NumIac];
    dbsrClr.dacRdHit = clrWord[dbgPkg::DbsrDacRdHit +: dbgPkg::NumDac];
    dbsrClr.dacWrHit = clrWord[dbgPkg::DbsrDacWrHit +: dbgPkg::NumDac];
  end

  // Read mux, current values before any update at this edge
  always_comb
  begin
    case (sprReq.sel)
      dbgPkg::SelDbcr0: rdWord = dbcr0;
      dbgPkg::SelDbcr1: rdWord = dbcr1;
      dbgPkg::SelDbsr:  rdWord = dbsrWord;
      default:          rdWord = '0;
    endcase
  end

  // **************************************************************************
  // Register storage
  // **************************************************************************

  always_ff @(posedge CB)
  begin
    if (reset)
    begin
      dbcr0 <= '0;
      dbcr1 <= '0;
    end
    else
    begin
      if (wrFire && sprReq.sel == dbgPkg::SelDbcr0)
        dbcr0 <= sprReq.data & dbgPkg::Dbcr0WrMask;
      if (wrFire && sprReq.sel == dbgPkg::SelDbcr1)
        dbcr1 <= sprReq.data & dbgPkg::Dbcr1WrMask;
    end
  end

  // Hardware set wins over a software clear
  always_ff @(posedge CB)
  begin
    if (reset)
      dbsr <= '0;
    else
      dbsr <= (dbsr & ~dbsrClr) | eventSet;
  end

  // Held read response
  always_ff @(posedge CB)
  begin
    if (reset)
      sprRspValid <= 1'b0;
    else if (rdFire)
      sprRspValid <= 1'b1;
    else if (sprRspReady)
      sprRspValid <= 1'b0;
  end

  always_ff @(posedge CB)
  begin
    if (rdFire)
      sprRspData <= rdWord;
  end

  // Control field decode
  assign ctl.edm      = dbcr0[dbgPkg::Dbcr0Edm];
  assign ctl.idm      = dbcr0[dbgPkg::Dbcr0Idm];
  assign ctl.iacEn    = dbcr0[dbgPkg::Dbcr0IacEn +: dbgPkg::NumIac];
  assign ctl.iac12Rng = dbcr0[dbgPkg::Dbcr0Iac12Rng];
  assign ctl.iac34Rng = dbcr0[dbgPkg::Dbcr0Iac34Rng];
  assign ctl.dacRdEn  = dbcr1[dbgPkg::Dbcr1DacRdEn +: dbgPkg::NumDac];
  assign ctl.dacWrEn  = dbcr1[dbgPkg::Dbcr1DacWrEn +: dbgPkg::NumDac];
  assign ctl.dacRng   = dbcr1[dbgPkg::Dbcr1DacRng];

  assign dbsrEvents = dbsr;

endmodule

//--- rtl/dbgTop.sv
/*
  Debug control top level
  Connects the SPR register block, the IAC and DAC matchers and the
  event control.
*/
`timescale 1ns/1ps

module dbgTop
(
  input  logic                        CB,
  input  logic                        reset,
  input  logic                        sprReqValid,
  input  dbgPkg::sprReq_t             sprReq,
  output logic                        sprReqReady,
  output logic                        sprRspValid,
  output logic [0:dbgPkg::SprWidth-1] sprRspData,
  input  logic                        sprRspReady,
  input  dbgPkg::iacCmp_t             instCmp,
  input  dbgPkg::dacCmp_t             dataCmp,
  input  logic                        wbFlush,
  input  logic                        msrDE,
  output logic                        debugIntrp,
  output logic                        stopReq
);

  dbgPkg::dbgCtl_t         ctl;
  dbgPkg::dbgEvents_t      dbsrEvents;
  dbgPkg::dbgEvents_t      eventSet;
  logic [1:dbgPkg::NumIac] wbIacHit;
  logic [1:dbgPkg::NumDac] wbDacRdHit;
  logic [1:dbgPkg::NumDac] wbDacWrHit;

  dbgSprRegs uSprRegs
  (
    .CB          (CB),
    .reset       (reset),
    .sprReqValid (sprReqValid),
    .sprReq      (sprReq),
    .sprReqReady (sprReqReady),
    .sprRspValid (sprRspValid),
    .sprRspData  (sprRspData),
    .sprRspReady (sprRspReady),
    .eventSet    (eventSet),
    .ctl         (ctl),
    .dbsrEvents  (dbsrEvents)
  );

  dbgIacMatch uIacMatch
  (
    .CB       (CB),
    .reset    (reset),
    .ctl      (ctl),
    .instCmp  (instCmp),
    .wbIacHit (wbIacHit)
  );

  dbgDacMatch uDacMatch
  (
    .CB         (CB),
    .reset      (reset),
    .ctl        (ctl),
    .dataCmp    (dataCmp),
    .wbDacRdHit (wbDacRdHit),
    .wbDacWrHit (wbDacWrHit)
  );

  dbgEventCtl uEventCtl
  (
    .ctl        (ctl),
    .wbIacHit   (wbIacHit),
    .wbDacRdHit (wbDacRdHit),
    .wbDacWrHit (wbDacWrHit),
    .wbFlush    (wbFlush),
    .msrDE      (msrDE),
    .dbsrEvents (dbsrEvents),
    .eventSet   (eventSet),
    .debugIntrp (debugIntrp),
    .stopReq    (stopReq)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build the debug control testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module dbgTb -o dbgSim \
  && ./obj_dir/dbgSim > sim.log 2>&1 \
  && cat sim.log \
  && grep -qx "all tests passed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
